// File: design/uncore_pkg.sv
package uncore_pkg;

    // ==================================================
    // Widths fixed by the core architecture
    // ==================================================
    localparam int RW          = 16;  // Core register width
    localparam int WB_ADDR_W   = 24;  // Bus address width
    localparam int PAGE_OFS_W  = 12;  // Untranslated offset bits
    localparam int PAGE_IDX_W  = 4;
    localparam int PHYS_PAGE_W = 12;
    localparam int PAGES       = 1 << PAGE_IDX_W;  // Page table entries
    localparam int CORES       = 2;
    localparam int DBG_W       = 36;

    // ==================================================
    // Special-register addresses
    // ==================================================
    typedef enum logic [RW-1:0] {
        SREG_IMMU_MAP    = 16'h0003,  // data[15:12] index, data[11:0] page
        SREG_DMMU_MAP    = 16'h0004,
        SREG_DMMU_CACHE  = 16'h0005,  // Bit n marks data page n cacheable
        SREG_MCINT_SET   = 16'h0009,
        SREG_MCINT_RESET = 16'h000A,
        SREG_MCDISABLE   = 16'h000B   // Core 0 only
    } sreg_addr_e;

    // ==================================================
    // Bus structs
    // ==================================================
    typedef struct packed {
        sreg_addr_e    addr;
        logic [RW-1:0] data;
        logic          we;
    } sr_bus_t;

    typedef struct packed {
        logic instr_page;
        logic data_page;
    } core_page_ctl_t;

endpackage

// File: design/immu.sv
module immu import uncore_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [RW-1:0]        i_addr,
    input  sr_bus_t              i_sr,
    input  logic                 i_page_en,
    output logic [WB_ADDR_W-1:0] o_addr
);

    logic [PHYS_PAGE_W-1:0] page_tbl [PAGES];

    logic                   map_we;
    logic [PAGE_IDX_W-1:0]  map_idx;
    logic [PHYS_PAGE_W-1:0] map_page;
    logic [PAGE_IDX_W-1:0]  cur_idx;

    // ==================================================
    // Page table writes
    // ==================================================
    assign map_we   = i_sr.we && (i_sr.addr == SREG_IMMU_MAP);
    assign map_idx  = i_sr.data[RW-1 -: PAGE_IDX_W];
    assign map_page = i_sr.data[PHYS_PAGE_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < PAGES; i++) begin
                page_tbl[i] <= '0;
            end
        end else if (map_we) begin
            page_tbl[map_idx] <= map_page;  // Visible from next cycle
        end
    end

    // ==================================================
    // Translation
    // ==================================================
    assign cur_idx = i_addr[RW-1 -: PAGE_IDX_W];

    always_comb begin
        if (i_page_en) begin
            o_addr = {page_tbl[cur_idx], i_addr[PAGE_OFS_W-1:0]};
        end else begin
            o_addr = {{(WB_ADDR_W-RW){1'b0}}, i_addr};  // Flat mapping
        end
    end

endmodule

// File: design/dmmu.sv
module dmmu import uncore_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [RW-1:0]        i_addr,
    input  sr_bus_t              i_sr,
    input  logic                 i_page_en,
    output logic [WB_ADDR_W-1:0] o_addr,
    output logic                 o_cacheable
);

    logic [PHYS_PAGE_W-1:0] page_tbl [PAGES];
    logic [PAGES-1:0]       cache_mask;

    logic                   map_we;
    logic                   mask_we;
    logic [PAGE_IDX_W-1:0]  map_idx;
    logic [PHYS_PAGE_W-1:0] map_page;
    logic [PAGE_IDX_W-1:0]  cur_idx;

    // ==================================================
    // Special-register decode
    // ==================================================
    assign map_we   = i_sr.we && (i_sr.addr == SREG_DMMU_MAP);
    assign mask_we  = i_sr.we && (i_sr.addr == SREG_DMMU_CACHE);
    assign map_idx  = i_sr.data[RW-1 -: PAGE_IDX_W];
    assign map_page = i_sr.data[PHYS_PAGE_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < PAGES; i++) begin
                page_tbl[i] <= '0;
            end
        end else if (map_we) begin
            page_tbl[map_idx] <= map_page;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cache_mask <= '0;  // Nothing cacheable out of reset
        end else if (mask_we) begin
            cache_mask <= i_sr.data[PAGES-1:0];
        end
    end

    // ==================================================
    // Translation and cacheable flag
    // ==================================================
    assign cur_idx = i_addr[RW-1 -: PAGE_IDX_W];

    always_comb begin
        if (i_page_en) begin
            o_addr      = {page_tbl[cur_idx], i_addr[PAGE_OFS_W-1:0]};
            o_cacheable = cache_mask[cur_idx];
        end else begin
            o_addr      = {{(WB_ADDR_W-RW){1'b0}}, i_addr};
            o_cacheable = 1'b0;  // Unpaged accesses bypass the cache
        end
    end

endmodule

// File: design/multicore_ctrl.sv
module multicore_ctrl import uncore_pkg::*; (
    input  logic             i_clk,
    input  logic             i_rst,
    input  sr_bus_t          i_sr0,
    input  sr_bus_t          i_sr1,
    input  logic [DBG_W-1:0] i_c0_dbg,
    input  logic [DBG_W-1:0] i_c1_dbg,
    input  logic             i_dbg_sel,
    input  logic             i_irq,
    output logic [RW-1:0]    o_sr0_rdata,
    output logic [RW-1:0]    o_sr1_rdata,
    output logic             o_c0_core_int,
    output logic             o_c1_core_int,
    output logic             o_c1_disable,
    output logic [DBG_W-1:0] o_dbg_out,
    output logic             o_irq0
);

    sr_bus_t          sr [CORES];
    logic [CORES-1:0] irq_set;
    logic [CORES-1:0] irq_clr;
    logic [CORES-1:0] irq_state;
    logic [CORES-1:0] irq_next;
    logic             c1_hold;
    logic             hold_we;

    assign sr[0] = i_sr0;
    assign sr[1] = i_sr1;

    // ==================================================
    // Inter-core interrupt register
    // ==================================================
    always_comb begin
        for (int c = 0; c < CORES; c++) begin
            irq_set[c] = sr[c].we && (sr[c].addr == SREG_MCINT_SET);
            irq_clr[c] = sr[c].we && (sr[c].addr == SREG_MCINT_RESET);
        end
    end

    // Clears first in core order, then sets, so a set wins
    always_comb begin
        irq_next = irq_state;
        for (int c = 0; c < CORES; c++) begin
            if (irq_clr[c]) begin
                irq_next = irq_next & ~sr[c].data[CORES-1:0];
            end
        end
        for (int c = 0; c < CORES; c++) begin
            if (irq_set[c]) begin
                irq_next = irq_next | sr[c].data[CORES-1:0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            irq_state <= '0;
        end else begin
            irq_state <= irq_next;
        end
    end

    assign o_c0_core_int = irq_state[0];
    assign o_c1_core_int = irq_state[1];
    assign o_sr0_rdata   = {{(RW-CORES){1'b0}}, irq_state};
    assign o_sr1_rdata   = {{(RW-CORES){1'b0}}, irq_state};

    // ==================================================
    // Core-1 hold, debug select, interrupt routing
    // ==================================================
    assign hold_we = i_sr0.we && (i_sr0.addr == SREG_MCDISABLE);  // Core 0 only

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            c1_hold <= 1'b1;  // Core 1 waits for release
        end else if (hold_we) begin
            c1_hold <= i_sr0.data[1];
        end
    end

    assign o_c1_disable = c1_hold;
    assign o_dbg_out    = i_dbg_sel ? i_c1_dbg : i_c0_dbg;
    assign o_irq0       = i_irq;

endmodule

// File: design/upper_core_logic.sv
module upper_core_logic import uncore_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic [RW-1:0]        i_fetch0_addr,
    input  logic [RW-1:0]        i_data0_addr,
    input  logic [RW-1:0]        i_fetch1_addr,
    input  logic [RW-1:0]        i_data1_addr,
    input  sr_bus_t              i_sr0,
    input  sr_bus_t              i_sr1,
    input  core_page_ctl_t       i_pg0,
    input  core_page_ctl_t       i_pg1,
    input  logic [DBG_W-1:0]     i_c0_dbg,
    input  logic [DBG_W-1:0]     i_c1_dbg,
    input  logic                 i_dbg_sel,
    input  logic                 i_irq,
    output logic [WB_ADDR_W-1:0] o_fetch0_addr_paged,
    output logic [WB_ADDR_W-1:0] o_data0_addr_paged,
    output logic [WB_ADDR_W-1:0] o_fetch1_addr_paged,
    output logic [WB_ADDR_W-1:0] o_data1_addr_paged,
    output logic                 o_data0_cacheable,
    output logic                 o_data1_cacheable,
    output logic [RW-1:0]        o_sr0_rdata,
    output logic [RW-1:0]        o_sr1_rdata,
    output logic                 o_c0_core_int,
    output logic                 o_c1_core_int,
    output logic                 o_c1_disable,
    output logic [DBG_W-1:0]     o_dbg_out,
    output logic                 o_irq0
);

    // ==================================================
    // Core 0 MMUs
    // ==================================================
    immu i_mmu_0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_addr    (i_fetch0_addr),
        .i_sr      (i_sr0),
        .i_page_en (i_pg0.instr_page),
        .o_addr    (o_fetch0_addr_paged)
    );

    dmmu d_mmu_0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_addr      (i_data0_addr),
        .i_sr        (i_sr0),
        .i_page_en   (i_pg0.data_page),
        .o_addr      (o_data0_addr_paged),
        .o_cacheable (o_data0_cacheable)
    );

    // ==================================================
    // Core 1 MMUs
    // ==================================================
    immu i_mmu_1 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_addr    (i_fetch1_addr),
        .i_sr      (i_sr1),
        .i_page_en (i_pg1.instr_page),
        .o_addr    (o_fetch1_addr_paged)
    );

    dmmu d_mmu_1 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_addr      (i_data1_addr),
        .i_sr        (i_sr1),
        .i_page_en   (i_pg1.data_page),
        .o_addr      (o_data1_addr_paged),
        .o_cacheable (o_data1_cacheable)
    );

    // Shared inter-core control
    multicore_ctrl mc_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_sr0         (i_sr0),
        .i_sr1         (i_sr1),
        .i_c0_dbg      (i_c0_dbg),
        .i_c1_dbg      (i_c1_dbg),
        .i_dbg_sel     (i_dbg_sel),
        .i_irq         (i_irq),
        .o_sr0_rdata   (o_sr0_rdata),
        .o_sr1_rdata   (o_sr1_rdata),
        .o_c0_core_int (o_c0_core_int),
        .o_c1_core_int (o_c1_core_int),
        .o_c1_disable  (o_c1_disable),
        .o_dbg_out     (o_dbg_out),
        .o_irq0        (o_irq0)
    );

endmodule

// File: dv/upper_core_logic_assert.sv
module upper_core_logic_assert import uncore_pkg::*; (
    input logic                 i_clk,
    input logic                 i_rst,
    input sr_bus_t              i_sr0,
    input sr_bus_t              i_sr1,
    input core_page_ctl_t       i_pg0,
    input core_page_ctl_t       i_pg1,
    input logic [RW-1:0]        i_fetch0_addr,
    input logic [RW-1:0]        i_data0_addr,
    input logic [RW-1:0]        i_fetch1_addr,
    input logic [RW-1:0]        i_data1_addr,
    input logic [WB_ADDR_W-1:0] o_fetch0_addr_paged,
    input logic [WB_ADDR_W-1:0] o_data0_addr_paged,
    input logic [WB_ADDR_W-1:0] o_fetch1_addr_paged,
    input logic [WB_ADDR_W-1:0] o_data1_addr_paged,
    input logic                 o_c0_core_int,
    input logic                 o_c1_core_int,
    input logic                 o_c1_disable
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [CORES-1:0] set_hit;  // Interrupt bits set by this cycle's writes
    int               fail_count = 0;

    assign set_hit = ({CORES{i_sr0.we && i_sr0.addr == SREG_MCINT_SET}} & i_sr0.data[1:0])
                   | ({CORES{i_sr1.we && i_sr1.addr == SREG_MCINT_SET}} & i_sr1.data[1:0]);

    property p_flat(logic en, logic [RW-1:0] a, logic [WB_ADDR_W-1:0] y);
        @(posedge i_clk) !en |-> (y == {{(WB_ADDR_W-RW){1'b0}}, a});
    endproperty

    a_hold_after_reset: assert property (@(posedge i_clk) $fell(i_rst) |-> o_c1_disable)
        else begin
            $error("Core 1 hold bit is low in the first cycle after reset");
            fail_count++;
        end
    a_int0_rise: assert property (@(posedge i_clk) $rose(o_c0_core_int) |-> $past(set_hit[0]))
        else begin
            $error("Core 0 interrupt rose without a set write");
            fail_count++;
        end
    a_int1_rise: assert property (@(posedge i_clk) $rose(o_c1_core_int) |-> $past(set_hit[1]))
        else begin
            $error("Core 1 interrupt rose without a set write");
            fail_count++;
        end

    a_flat_f0: assert property (p_flat(i_pg0.instr_page, i_fetch0_addr, o_fetch0_addr_paged))
        else begin
            $error("Core 0 fetch address translated with paging off");
            fail_count++;
        end
    a_flat_d0: assert property (p_flat(i_pg0.data_page, i_data0_addr, o_data0_addr_paged))
        else begin
            $error("Core 0 data address translated with paging off");
            fail_count++;
        end
    a_flat_f1: assert property (p_flat(i_pg1.instr_page, i_fetch1_addr, o_fetch1_addr_paged))
        else begin
            $error("Core 1 fetch address translated with paging off");
            fail_count++;
        end
    a_flat_d1: assert property (p_flat(i_pg1.data_page, i_data1_addr, o_data1_addr_paged))
        else begin
            $error("Core 1 data address translated with paging off");
            fail_count++;
        end

endmodule

bind upper_core_logic upper_core_logic_assert u_assert (.*);

// File: dv/tb_upper_core_logic.sv
module tb_upper_core_logic import uncore_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic                 i_clk = 1'b0;
    logic                 i_rst;
    logic [RW-1:0]        i_fetch0_addr, i_data0_addr, i_fetch1_addr, i_data1_addr;
    sr_bus_t              i_sr0, i_sr1;
    core_page_ctl_t       i_pg0, i_pg1;
    logic [DBG_W-1:0]     i_c0_dbg, i_c1_dbg;
    logic                 i_dbg_sel, i_irq;
    logic [WB_ADDR_W-1:0] o_fetch0_addr_paged, o_data0_addr_paged;
    logic [WB_ADDR_W-1:0] o_fetch1_addr_paged, o_data1_addr_paged;
    logic                 o_data0_cacheable, o_data1_cacheable;
    logic [RW-1:0]        o_sr0_rdata, o_sr1_rdata;
    logic                 o_c0_core_int, o_c1_core_int, o_c1_disable, o_irq0;
    logic [DBG_W-1:0]     o_dbg_out;

    integer seed = 32'ha7b1_8007;
    int     errors = 0;
    int     checks = 0;
    int     rst_left = 10;  // Reset edges still to go

    // ==================================================
    // Reference model state
    // ==================================================
    logic [PHYS_PAGE_W-1:0] m_itbl [CORES][PAGES];
    logic [PHYS_PAGE_W-1:0] m_dtbl [CORES][PAGES];
    logic [PAGES-1:0]       m_mask [CORES];
    logic [CORES-1:0]       m_irq;
    logic                   m_hold;

    upper_core_logic dut0 (.*);

    always #2 i_clk = ~i_clk;

    function automatic logic [WB_ADDR_W-1:0] xlate(input logic [PHYS_PAGE_W-1:0] page,
                                                   input logic [RW-1:0] a, input logic en);
        return en ? {page, a[PAGE_OFS_W-1:0]} : {{(WB_ADDR_W-RW){1'b0}}, a};
    endfunction

    // Mode 0 idle, 1 maps, 2 masks and maps, 3 interrupts, 4 hold, else anything
    function automatic logic [RW-1:0] pick_addr(input int mode);
        logic [31:0] r;
        r = $random(seed);
        case (mode)
            1:       pick_addr = r[0] ? SREG_IMMU_MAP : SREG_DMMU_MAP;
            2:       pick_addr = r[0] ? SREG_DMMU_CACHE : SREG_DMMU_MAP;
            3:       pick_addr = r[0] ? SREG_MCINT_SET : SREG_MCINT_RESET;
            4:       pick_addr = SREG_MCDISABLE;
            default: begin
                case (r[2:0])
                    3'd0:    pick_addr = SREG_IMMU_MAP;
                    3'd1:    pick_addr = SREG_DMMU_MAP;
                    3'd2:    pick_addr = SREG_DMMU_CACHE;
                    3'd3:    pick_addr = SREG_MCINT_SET;
                    3'd4:    pick_addr = SREG_MCINT_RESET;
                    3'd5:    pick_addr = SREG_MCDISABLE;
                    3'd6:    pick_addr = 16'h0000;  // Unused addresses
                    default: pick_addr = 16'h0007;
                endcase
            end
        endcase
    endfunction

    task automatic drive_random(input int mode);
        logic [31:0] r;
        r = $random(seed);
        if (rst_left > 0) rst_left--;
        i_rst         <= (rst_left != 0);
        i_fetch0_addr <= $random(seed);
        i_data0_addr  <= $random(seed);
        i_fetch1_addr <= $random(seed);
        i_data1_addr  <= $random(seed);
        i_pg0         <= (mode == 0) ? 2'b11 : r[1:0];  // Idle cycles keep paging on
        i_pg1         <= (mode == 0) ? 2'b11 : r[3:2];
        i_dbg_sel     <= r[4];
        i_irq         <= r[5];
        i_c0_dbg      <= {$random(seed), $random(seed)};
        i_c1_dbg      <= {$random(seed), $random(seed)};
        i_sr0.addr    <= sreg_addr_e'(pick_addr(mode));
        i_sr0.data    <= $random(seed);
        i_sr0.we      <= (mode != 0) && r[6];
        i_sr1.addr    <= sreg_addr_e'(pick_addr(mode));
        i_sr1.data    <= $random(seed);
        i_sr1.we      <= (mode != 0) && r[7];
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check("o_fetch0_addr_paged", o_fetch0_addr_paged,
              xlate(m_itbl[0][i_fetch0_addr[15:12]], i_fetch0_addr, i_pg0.instr_page));
        check("o_data0_addr_paged", o_data0_addr_paged,
              xlate(m_dtbl[0][i_data0_addr[15:12]], i_data0_addr, i_pg0.data_page));
        check("o_fetch1_addr_paged", o_fetch1_addr_paged,
              xlate(m_itbl[1][i_fetch1_addr[15:12]], i_fetch1_addr, i_pg1.instr_page));
        check("o_data1_addr_paged", o_data1_addr_paged,
              xlate(m_dtbl[1][i_data1_addr[15:12]], i_data1_addr, i_pg1.data_page));
        check("o_data0_cacheable", o_data0_cacheable,
              i_pg0.data_page & m_mask[0][i_data0_addr[15:12]]);
        check("o_data1_cacheable", o_data1_cacheable,
              i_pg1.data_page & m_mask[1][i_data1_addr[15:12]]);
        check("o_sr0_rdata", o_sr0_rdata, {{(RW-CORES){1'b0}}, m_irq});
        check("o_sr1_rdata", o_sr1_rdata, {{(RW-CORES){1'b0}}, m_irq});
        check("o_c0_core_int", o_c0_core_int, m_irq[0]);
        check("o_c1_core_int", o_c1_core_int, m_irq[1]);
        check("o_c1_disable", o_c1_disable, m_hold);
        check("o_dbg_out", o_dbg_out, i_dbg_sel ? i_c1_dbg : i_c0_dbg);
        check("o_irq0", o_irq0, i_irq);
    endtask

    // Applies the inputs that the next rising edge will take
    task automatic update_model();
        sr_bus_t          sr [CORES];
        logic [CORES-1:0] nxt;
        sr[0] = i_sr0;
        sr[1] = i_sr1;
        if (i_rst) begin
            for (int c = 0; c < CORES; c++) begin
                for (int p = 0; p < PAGES; p++) begin
                    m_itbl[c][p] = '0;
                    m_dtbl[c][p] = '0;
                end
                m_mask[c] = '0;
            end
            m_irq  = '0;
            m_hold = 1'b1;
        end else begin
            nxt = m_irq;
            for (int c = 0; c < CORES; c++) begin
                if (sr[c].we) begin
                    case (sr[c].addr)
                        SREG_IMMU_MAP:    m_itbl[c][sr[c].data[15:12]] = sr[c].data[11:0];
                        SREG_DMMU_MAP:    m_dtbl[c][sr[c].data[15:12]] = sr[c].data[11:0];
                        SREG_DMMU_CACHE:  m_mask[c] = sr[c].data;
                        SREG_MCINT_RESET: nxt = nxt & ~sr[c].data[1:0];
                        SREG_MCDISABLE:   if (c == 0) m_hold = sr[c].data[1];
                        default:          ;
                    endcase
                end
            end
            for (int c = 0; c < CORES; c++) begin
                if (sr[c].we && sr[c].addr == SREG_MCINT_SET) nxt = nxt | sr[c].data[1:0];
            end
            m_irq = nxt;  // Sets win over clears
        end
    endtask

    task automatic finish_cycle();
        @(negedge i_clk);
        if (!i_rst) check_outputs();
        update_model();
    endtask

    task automatic cycle(input int mode);
        @(posedge i_clk);
        drive_random(mode);
        finish_cycle();
    endtask

    task automatic write_sr(input int core, input logic [RW-1:0] addr, input logic [RW-1:0] data);
        @(posedge i_clk);
        drive_random(0);
        if (core == 0) i_sr0 <= '{addr: sreg_addr_e'(addr), data: data, we: 1'b1};
        else i_sr1 <= '{addr: sreg_addr_e'(addr), data: data, we: 1'b1};
        finish_cycle();
    endtask

    task automatic wait_core0_int(input int limit);
        int n;
        n = 0;
        while (o_c0_core_int !== 1'b1 && n < limit) begin
            cycle(0);
            n++;
        end
        if (o_c0_core_int !== 1'b1) begin
            errors++;
            $display("Timeout: core 0 interrupt did not rise within %0d cycles", limit);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        i_rst         = 1'b1;
        i_fetch0_addr = '0;
        i_data0_addr  = '0;
        i_fetch1_addr = '0;
        i_data1_addr  = '0;
        i_sr0         = '0;
        i_sr1         = '0;
        i_pg0         = '0;
        i_pg1         = '0;
        i_c0_dbg      = '0;
        i_c1_dbg      = '0;
        i_dbg_sel     = 1'b0;
        i_irq         = 1'b0;
        repeat (10) cycle(0);   // Reset
        repeat (20) cycle(0);   // Reset state, all pages map to zero
        repeat (400) cycle(1);
        repeat (300) cycle(2);
        repeat (400) cycle(3);  // Includes simultaneous set and clear
        repeat (100) cycle(4);
        write_sr(0, SREG_MCINT_RESET, 16'h0003);
        write_sr(1, SREG_MCINT_SET, 16'h0001);
        wait_core0_int(8);
        write_sr(0, SREG_MCDISABLE, 16'h0000);  // Release core 1
        repeat (600) cycle(5);
        errors += dut0.u_assert.fail_count;  // Bound assertion failures
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
design/uncore_pkg.sv
design/immu.sv
design/dmmu.sv
design/multicore_ctrl.sv
design/upper_core_logic.sv
dv/upper_core_logic_assert.sv
dv/tb_upper_core_logic.sv
